/* include/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// opcodes understood by the control unit
`define RTYPE_OPCODE            6'b000000
`define ADDI_OPCODE             6'b001000
`define ANDI_OPCODE             6'b001100
`define BEQ_OPCODE              6'b000100
`define JUMP_OPCODE             6'b000010

// instruction fields
`define OPCODE_FIELD            31:26
`define RS_FIELD                25:21
`define RT_FIELD                20:16
`define RD_FIELD                15:11
`define IMM_FIELD               15:0
`define FUNC_FIELD              5:0
`define JIDX_FIELD              25:0

// second alu operand
`define RT_ALU_SRC              1'b0
`define INMEDIATE_ALU_SRC       1'b1

// immediate extension
`define SIGNED_EXTENSION_MODE   2'b00
`define UNSIGNED_EXTENSION_MODE 2'b01

// instruction memory, in words
`define IMEM_DEPTH              64
`define IMEM_ADDR_BITS          6

`endif

/* source/control_unit.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module control_unit (
    input  mips_pkg::word_t      i_instruction,
    output logic                 o_alu_src,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_reg_write,
    output mips_pkg::reg_addr_t  o_reg_dir_to_write,
    output logic                 o_branch,
    output logic                 o_jump,
    output mips_pkg::ext_mode_t  o_extension_mode,
    output mips_pkg::word_size_t o_word_size
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;

    assign opcode = i_instruction[`OPCODE_FIELD];
    assign rt     = i_instruction[`RT_FIELD];
    assign rd     = i_instruction[`RD_FIELD];

    always_comb begin
        // defaults match the no-op decode
        o_alu_src          = `RT_ALU_SRC;
        o_extension_mode   = `SIGNED_EXTENSION_MODE;
        o_mem_read         = 1'b0;
        o_mem_write        = 1'b0;
        o_reg_write        = 1'b0;
        o_branch           = 1'b0;
        o_jump             = 1'b0;
        o_word_size        = 3'b000;
        o_reg_dir_to_write = '0;

        case (opcode)
            `RTYPE_OPCODE: begin
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rd;
            end
            `ADDI_OPCODE: begin
                o_alu_src          = `INMEDIATE_ALU_SRC;
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rt;
            end
            `ANDI_OPCODE: begin
                // logical immediates are zero extended
                o_alu_src          = `INMEDIATE_ALU_SRC;
                o_extension_mode   = `UNSIGNED_EXTENSION_MODE;
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rt;
            end
            `BEQ_OPCODE: begin
                o_branch = 1'b1;
            end
            `JUMP_OPCODE: begin
                o_jump = 1'b1;
            end
            default: begin
                o_reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* source/if_id_buffer.sv */
`timescale 1ns/1ps

module if_id_buffer (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_stall,
    input  logic            i_squash,
    input  mips_pkg::word_t i_instruction,
    input  mips_pkg::word_t i_pc_plus4,
    input  logic            i_valid,
    output mips_pkg::word_t o_instruction,
    output mips_pkg::word_t o_pc_plus4,
    output logic            o_valid
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            // the word behind a taken redirect is dropped
            o_valid <= i_valid && !i_squash;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_pc_plus4 <= i_pc_plus4;
            if (i_squash) begin
                o_instruction <= '0;
            end else begin
                o_instruction <= i_instruction;
            end
        end
    end

endmodule

/* source/instruction_decode.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module instruction_decode (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_stall,
    input  mips_pkg::word_t      i_instruction,
    input  mips_pkg::word_t      i_pc_plus4,
    input  logic                 i_valid,
    input  logic                 i_wb_write,
    input  mips_pkg::reg_addr_t  i_wb_reg,
    input  mips_pkg::word_t      i_wb_data,
    output logic                 o_redirect,
    output mips_pkg::word_t      o_redirect_target,
    output logic                 o_valid,
    output mips_pkg::word_t      o_pc_plus4,
    output mips_pkg::word_t      o_read_data_1,
    output mips_pkg::word_t      o_read_data_2,
    output mips_pkg::word_t      o_immediate,
    output mips_pkg::opcode_t    o_func_code,
    output logic                 o_alu_src,
    output logic                 o_mem_read,
    output logic                 o_mem_write,
    output logic                 o_reg_write,
    output mips_pkg::reg_addr_t  o_reg_dir_to_write,
    output mips_pkg::word_size_t o_word_size
);

    logic                 alu_src, mem_read, mem_write, reg_write, branch, jump;
    mips_pkg::reg_addr_t  reg_dir_to_write;
    mips_pkg::ext_mode_t  extension_mode;
    mips_pkg::word_size_t word_size;
    mips_pkg::word_t      read_data_1, read_data_2;
    mips_pkg::word_t      imm_sext, imm_zext, branch_target, jump_target;
    logic                 issue;

    control_unit u_control (
        .i_instruction      (i_instruction),
        .o_alu_src          (alu_src),
        .o_mem_read         (mem_read),
        .o_mem_write        (mem_write),
        .o_reg_write        (reg_write),
        .o_reg_dir_to_write (reg_dir_to_write),
        .o_branch           (branch),
        .o_jump             (jump),
        .o_extension_mode   (extension_mode),
        .o_word_size        (word_size)
    );

    register_file u_regs (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_read_reg_1  (i_instruction[`RS_FIELD]),
        .i_read_reg_2  (i_instruction[`RT_FIELD]),
        .i_write       (i_wb_write),
        .i_write_reg   (i_wb_reg),
        .i_write_data  (i_wb_data),
        .o_read_data_1 (read_data_1),
        .o_read_data_2 (read_data_2)
    );

    assign imm_sext = {{16{i_instruction[15]}}, i_instruction[`IMM_FIELD]};
    assign imm_zext = {16'b0, i_instruction[`IMM_FIELD]};

    assign branch_target = i_pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jump_target   = {i_pc_plus4[31:28], i_instruction[`JIDX_FIELD], 2'b00};

    assign issue = i_valid && !i_stall;

    // branch resolved here, compare on the raw register reads
    assign o_redirect        = issue && (jump || (branch && read_data_1 == read_data_2));
    assign o_redirect_target = jump ? jump_target : branch_target;

    always_ff @(posedge i_clk) begin
        if (i_reset || !issue) begin
            o_valid            <= 1'b0;
            o_alu_src          <= 1'b0;
            o_mem_read         <= 1'b0;
            o_mem_write        <= 1'b0;
            o_reg_write        <= 1'b0;
            o_reg_dir_to_write <= '0;
            o_word_size        <= '0;
        end else begin
            o_valid            <= 1'b1;
            o_alu_src          <= alu_src;
            o_mem_read         <= mem_read;
            o_mem_write        <= mem_write;
            o_reg_write        <= reg_write;
            o_reg_dir_to_write <= reg_dir_to_write;
            o_word_size        <= word_size;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc_plus4    <= i_pc_plus4;
        o_read_data_1 <= read_data_1;
        o_read_data_2 <= read_data_2;
        o_func_code   <= i_instruction[`FUNC_FIELD];
        if (extension_mode == `UNSIGNED_EXTENSION_MODE) begin
            o_immediate <= imm_zext;
        end else begin
            o_immediate <= imm_sext;
        end
    end

endmodule

/* source/instruction_fetch.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module instruction_fetch (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_stall,
    input  logic                       i_redirect,
    input  mips_pkg::word_t            i_redirect_target,
    input  logic                       i_imem_we,
    input  logic [`IMEM_ADDR_BITS-1:0] i_imem_addr,
    input  mips_pkg::word_t            i_imem_data,
    output mips_pkg::word_t            o_instruction,
    output mips_pkg::word_t            o_pc_plus4,
    output logic                       o_valid
);

    mips_pkg::word_t imem [0:`IMEM_DEPTH-1];
    mips_pkg::word_t pc;
    logic            running;

    // program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // running goes high one cycle after reset so the word at pc 0 is not skipped
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // hold, then redirect, then sequential
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (i_stall || !running) begin
            pc <= pc;
        end else if (i_redirect) begin
            pc <= i_redirect_target;
        end else begin
            pc <= o_pc_plus4;
        end
    end

    // word index of the pc
    assign o_instruction = imem[pc[`IMEM_ADDR_BITS+1:2]];
    assign o_pc_plus4    = pc + 32'd4;
    assign o_valid       = running;

endmodule

/* source/mips_front_end.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_front_end (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_stall,
    input  logic                       i_imem_we,
    input  logic [`IMEM_ADDR_BITS-1:0] i_imem_addr,
    input  mips_pkg::word_t            i_imem_data,
    input  logic                       i_wb_write,
    input  mips_pkg::reg_addr_t        i_wb_reg,
    input  mips_pkg::word_t            i_wb_data,
    output logic                       o_redirect,
    output mips_pkg::word_t            o_redirect_target,
    output logic                       o_valid,
    output mips_pkg::word_t            o_pc_plus4,
    output mips_pkg::word_t            o_read_data_1,
    output mips_pkg::word_t            o_read_data_2,
    output mips_pkg::word_t            o_immediate,
    output mips_pkg::opcode_t          o_func_code,
    output logic                       o_alu_src,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output logic                       o_reg_write,
    output mips_pkg::reg_addr_t        o_reg_dir_to_write,
    output mips_pkg::word_size_t       o_word_size
);

    mips_pkg::word_t if_instruction, if_pc_plus4;
    mips_pkg::word_t id_instruction, id_pc_plus4;
    logic            if_valid, id_valid;

    instruction_fetch u_fetch (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_stall           (i_stall),
        .i_redirect        (o_redirect),
        .i_redirect_target (o_redirect_target),
        .i_imem_we         (i_imem_we),
        .i_imem_addr       (i_imem_addr),
        .i_imem_data       (i_imem_data),
        .o_instruction     (if_instruction),
        .o_pc_plus4        (if_pc_plus4),
        .o_valid           (if_valid)
    );

    // a redirect also squashes the word fetched behind it
    if_id_buffer u_if_id (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_squash      (o_redirect),
        .i_instruction (if_instruction),
        .i_pc_plus4    (if_pc_plus4),
        .i_valid       (if_valid),
        .o_instruction (id_instruction),
        .o_pc_plus4    (id_pc_plus4),
        .o_valid       (id_valid)
    );

    instruction_decode u_decode (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_stall            (i_stall),
        .i_instruction      (id_instruction),
        .i_pc_plus4         (id_pc_plus4),
        .i_valid            (id_valid),
        .i_wb_write         (i_wb_write),
        .i_wb_reg           (i_wb_reg),
        .i_wb_data          (i_wb_data),
        .o_redirect         (o_redirect),
        .o_redirect_target  (o_redirect_target),
        .o_valid            (o_valid),
        .o_pc_plus4         (o_pc_plus4),
        .o_read_data_1      (o_read_data_1),
        .o_read_data_2      (o_read_data_2),
        .o_immediate        (o_immediate),
        .o_func_code        (o_func_code),
        .o_alu_src          (o_alu_src),
        .o_mem_read         (o_mem_read),
        .o_mem_write        (o_mem_write),
        .o_reg_write        (o_reg_write),
        .o_reg_dir_to_write (o_reg_dir_to_write),
        .o_word_size        (o_word_size)
    );

endmodule

/* source/mips_pkg.sv */
package mips_pkg;

    // instruction, pc or data word
    typedef logic [31:0] word_t;

    // register index, 32 registers
    typedef logic [4:0] reg_addr_t;

    // opcode and function code have the same width
    typedef logic [5:0] opcode_t;

    // memory access size code
    typedef logic [2:0] word_size_t;

    // signed or unsigned immediate extension
    typedef logic [1:0] ext_mode_t;

endpackage

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                i_clk,
    input  logic                i_reset,
    input  mips_pkg::reg_addr_t i_read_reg_1,
    input  mips_pkg::reg_addr_t i_read_reg_2,
    input  logic                i_write,
    input  mips_pkg::reg_addr_t i_write_reg,
    input  mips_pkg::word_t     i_write_data,
    output mips_pkg::word_t     o_read_data_1,
    output mips_pkg::word_t     o_read_data_2
);

    mips_pkg::word_t regs [0:31];

    // register 0 is never written and reads as zero
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_write && i_write_reg == addr) begin
            return i_write_data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && i_write_reg != '0) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    assign o_read_data_1 = read_port(i_read_reg_1);
    assign o_read_data_2 = read_port(i_read_reg_2);

endmodule

/* src.f */
+incdir+include
source/mips_pkg.sv
source/instruction_fetch.sv
source/if_id_buffer.sv
source/control_unit.sv
source/register_file.sv
source/instruction_decode.sv
source/mips_front_end.sv
verif/mips_front_end_checker.sv
verif/mips_front_end_tb.sv

/* verif/mips_front_end_checker.sv */
`timescale 1ns/1ps

module mips_front_end_checker (
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_stall,
    input logic                 i_redirect,
    input logic                 i_valid,
    input logic                 i_alu_src,
    input logic                 i_mem_read,
    input logic                 i_mem_write,
    input logic                 i_reg_write,
    input mips_pkg::reg_addr_t  i_reg_dir_to_write,
    input mips_pkg::word_size_t i_word_size
);

    int fail_count = 0;

    // a bubble carries no control
    a_bubble_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_valid |-> !(i_alu_src || i_mem_read || i_mem_write || i_reg_write)
                     && i_reg_dir_to_write == '0 && i_word_size == '0)
        else begin
            $error("control output high while o_valid is low");
            fail_count++;
        end

    // no load or store opcode is decoded by this front end
    a_no_mem_access: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_mem_read || i_mem_write))
        else begin
            $error("memory access control raised");
            fail_count++;
        end

    a_no_redirect_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |-> !i_redirect)
        else begin
            $error("redirect fired while stalled");
            fail_count++;
        end

endmodule

bind mips_front_end mips_front_end_checker u_checker (
    .i_clk              (i_clk),
    .i_reset            (i_reset),
    .i_stall            (i_stall),
    .i_redirect         (o_redirect),
    .i_valid            (o_valid),
    .i_alu_src          (o_alu_src),
    .i_mem_read         (o_mem_read),
    .i_mem_write        (o_mem_write),
    .i_reg_write        (o_reg_write),
    .i_reg_dir_to_write (o_reg_dir_to_write),
    .i_word_size        (o_word_size)
);

/* verif/mips_front_end_tb.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_front_end_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int PROG_WORDS   = `IMEM_DEPTH;
    localparam int SEED         = 95086;
    // load, preload and a stalled run, with a wide margin
    localparam int WATCHDOG_NS  = 10 * (PROG_WORDS + 32 + RESET_CYCLES) * CLK_PERIOD;

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_stall;
    logic                       i_imem_we;
    logic [`IMEM_ADDR_BITS-1:0] i_imem_addr;
    mips_pkg::word_t            i_imem_data;
    logic                       i_wb_write;
    mips_pkg::reg_addr_t        i_wb_reg;
    mips_pkg::word_t            i_wb_data;
    logic                       o_redirect;
    mips_pkg::word_t            o_redirect_target;
    logic                       o_valid;
    mips_pkg::word_t            o_pc_plus4;
    mips_pkg::word_t            o_read_data_1;
    mips_pkg::word_t            o_read_data_2;
    mips_pkg::word_t            o_immediate;
    mips_pkg::opcode_t          o_func_code;
    logic                       o_alu_src;
    logic                       o_mem_read;
    logic                       o_mem_write;
    logic                       o_reg_write;
    mips_pkg::reg_addr_t        o_reg_dir_to_write;
    mips_pkg::word_size_t       o_word_size;

    mips_pkg::word_t prog [0:PROG_WORDS-1];
    mips_pkg::word_t model_regs [0:31];
    int              expect_q [$];

    mips_front_end i_dut (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_stall            (i_stall),
        .i_imem_we          (i_imem_we),
        .i_imem_addr        (i_imem_addr),
        .i_imem_data        (i_imem_data),
        .i_wb_write         (i_wb_write),
        .i_wb_reg           (i_wb_reg),
        .i_wb_data          (i_wb_data),
        .o_redirect         (o_redirect),
        .o_redirect_target  (o_redirect_target),
        .o_valid            (o_valid),
        .o_pc_plus4         (o_pc_plus4),
        .o_read_data_1      (o_read_data_1),
        .o_read_data_2      (o_read_data_2),
        .o_immediate        (o_immediate),
        .o_func_code        (o_func_code),
        .o_alu_src          (o_alu_src),
        .o_mem_read         (o_mem_read),
        .o_mem_write        (o_mem_write),
        .o_reg_write        (o_reg_write),
        .o_reg_dir_to_write (o_reg_dir_to_write),
        .o_word_size        (o_word_size)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic compare_word(input string name, input mips_pkg::word_t got,
                                input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $realtime, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_reg(input string name, input mips_pkg::reg_addr_t got,
                               input mips_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $realtime, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_code(input string name, input mips_pkg::opcode_t got,
                                input mips_pkg::opcode_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $realtime, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $realtime, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_size(input string name, input mips_pkg::word_size_t got,
                                input mips_pkg::word_size_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $realtime, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // J and BEQ only jump forward by two to four words and stay in memory
    task automatic build_program();
        int                  kind;
        int                  target;
        mips_pkg::opcode_t   op;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        for (int w = 0; w < PROG_WORDS; w++) begin
            kind   = $urandom % 10;
            target = w + 2 + ($urandom % 3);
            rs     = 5'($urandom % 8);
            rt     = 5'($urandom % 8);
            rd     = 5'($urandom);
            if (target >= PROG_WORDS && kind < 2) begin
                kind = 2;
            end
            case (kind)
                0: prog[w] = {`JUMP_OPCODE, 26'(target)};
                1: prog[w] = {`BEQ_OPCODE, rs, rt, 16'(target - w - 1)};
                2, 3, 4: prog[w] = {`RTYPE_OPCODE, rs, rt, rd, 5'($urandom), 6'($urandom)};
                5, 6: prog[w] = {`ADDI_OPCODE, rs, rt, 16'($urandom)};
                7, 8: prog[w] = {`ANDI_OPCODE, rs, rt, 16'($urandom)};
                default: begin
                    op = 6'($urandom);
                    if (op inside {`RTYPE_OPCODE, `ADDI_OPCODE, `ANDI_OPCODE,
                                   `BEQ_OPCODE, `JUMP_OPCODE}) begin
                        op = 6'h3f;
                    end
                    prog[w] = {op, 26'($urandom)};
                end
            endcase
        end
    endtask

    // walk the program from pc 0, no delay slot
    task automatic build_expected();
        int              w;
        mips_pkg::word_t instr;
        w = 0;
        while (w < PROG_WORDS) begin
            expect_q.push_back(w);
            instr = prog[w];
            if (instr[`OPCODE_FIELD] == `JUMP_OPCODE) begin
                w = int'(instr[`JIDX_FIELD]);
            end else if (instr[`OPCODE_FIELD] == `BEQ_OPCODE &&
                         model_regs[instr[`RS_FIELD]] == model_regs[instr[`RT_FIELD]]) begin
                w = w + 1 + int'($signed(instr[`IMM_FIELD]));
            end else begin
                w++;
            end
        end
    endtask

    task automatic check_idle();
        compare_bit("o_valid", o_valid, 1'b0);
        compare_bit("o_alu_src", o_alu_src, 1'b0);
        compare_bit("o_mem_read", o_mem_read, 1'b0);
        compare_bit("o_mem_write", o_mem_write, 1'b0);
        compare_bit("o_reg_write", o_reg_write, 1'b0);
        compare_reg("o_reg_dir_to_write", o_reg_dir_to_write, '0);
        compare_size("o_word_size", o_word_size, '0);
    endtask

    task automatic check_output(input int w);
        mips_pkg::word_t     instr;
        mips_pkg::opcode_t   op;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t dest;
        mips_pkg::word_t     imm;
        logic                uses_imm;
        instr    = prog[w];
        op       = instr[`OPCODE_FIELD];
        rs       = instr[`RS_FIELD];
        rt       = instr[`RT_FIELD];
        uses_imm = (op == `ADDI_OPCODE) || (op == `ANDI_OPCODE);
        dest     = (op == `RTYPE_OPCODE) ? instr[`RD_FIELD] : (uses_imm ? rt : '0);
        if (op == `ANDI_OPCODE) begin
            imm = {16'b0, instr[`IMM_FIELD]};
        end else begin
            imm = {{16{instr[15]}}, instr[`IMM_FIELD]};
        end
        compare_word("o_pc_plus4", o_pc_plus4, mips_pkg::word_t'(w * 4 + 4));
        compare_word("o_read_data_1", o_read_data_1, model_regs[rs]);
        compare_word("o_read_data_2", o_read_data_2, model_regs[rt]);
        compare_word("o_immediate", o_immediate, imm);
        compare_code("o_func_code", o_func_code, instr[`FUNC_FIELD]);
        compare_bit("o_alu_src", o_alu_src, uses_imm);
        compare_bit("o_mem_read", o_mem_read, 1'b0);
        compare_bit("o_mem_write", o_mem_write, 1'b0);
        compare_bit("o_reg_write", o_reg_write, uses_imm || op == `RTYPE_OPCODE);
        compare_reg("o_reg_dir_to_write", o_reg_dir_to_write, dest);
        compare_size("o_word_size", o_word_size, '0);
    endtask

    // J always redirects, BEQ only when both register reads are equal
    task automatic check_redirect(input int w, input logic got,
                                  input mips_pkg::word_t got_target);
        mips_pkg::word_t instr;
        logic            taken;
        int              target;
        instr  = prog[w];
        taken  = 1'b0;
        target = 0;
        if (instr[`OPCODE_FIELD] == `JUMP_OPCODE) begin
            taken  = 1'b1;
            target = int'(instr[`JIDX_FIELD]);
        end else if (instr[`OPCODE_FIELD] == `BEQ_OPCODE &&
                     model_regs[instr[`RS_FIELD]] == model_regs[instr[`RT_FIELD]]) begin
            taken  = 1'b1;
            target = w + 1 + int'($signed(instr[`IMM_FIELD]));
        end
        compare_bit("o_redirect", got, taken);
        if (taken) begin
            compare_word("o_redirect_target", got_target, mips_pkg::word_t'(target * 4));
        end
    endtask

    task automatic check_assertions();
        if (i_dut.u_checker.fail_count != 0) begin
            $display("a bound assertion failed before %0t", $realtime);
            $display("*** FAILED ***");
            $fatal(1, "assertion failure in the checker");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int              idx;
        logic            seen_redirect;
        mips_pkg::word_t seen_target;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(SEED));
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_stall     = 1'b1;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        i_wb_write  = 1'b0;
        i_wb_reg    = '0;
        i_wb_data   = '0;
        build_program();
        // few distinct values so BEQ operands often match
        model_regs[0] = '0;
        for (int r = 1; r < 32; r++) begin
            model_regs[r] = 32'h0101_0101 * ($urandom % 4);
        end
        build_expected();

        // program load starts under reset, the pipeline stays stalled
        for (int c = 0; c < PROG_WORDS; c++) begin
            @(posedge i_clk);
            #1;
            check_idle();
            i_reset     = (c + 1 < RESET_CYCLES);
            i_imem_we   = 1'b1;
            i_imem_addr = c[`IMEM_ADDR_BITS-1:0];
            i_imem_data = prog[c];
        end
        for (int r = 1; r < 32; r++) begin
            @(posedge i_clk);
            #1;
            check_idle();
            i_imem_we  = 1'b0;
            i_wb_write = 1'b1;
            i_wb_reg   = r[4:0];
            i_wb_data  = model_regs[r];
        end
        @(posedge i_clk);
        #1;
        check_idle();
        i_wb_write = 1'b0;

        idx = 0;
        while (idx < expect_q.size()) begin
            i_stall = ($urandom % 5 == 0);
            // redirect is combinational, sample it mid cycle
            #1;
            seen_redirect = o_redirect;
            seen_target   = o_redirect_target;
            @(posedge i_clk);
            #1;
            check_assertions();
            if (o_valid === 1'b1) begin
                check_output(expect_q[idx]);
                check_redirect(expect_q[idx], seen_redirect, seen_target);
                idx++;
            end else begin
                check_idle();
                compare_bit("o_redirect", seen_redirect, 1'b0);
            end
        end

        if (i_dut.u_checker.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "assertion failure in the checker");
        end
    end

endmodule
